//--- logic/mbxGeometryPkg.sv
// Memory buffer geometry

package mbxGeometryPkg;

  ////////////////////////////////////////
  // Line and buffer size
  ////////////////////////////////////////

  // Words in one cache line, and so in the buffer
  localparam int wordsPerLine = 4;

  // Index width follows the word count
  localparam int wordIdxWidth = $clog2(wordsPerLine);

  ////////////////////////////////////////
  // Word types
  ////////////////////////////////////////

  // Index of one buffer word
  typedef logic [wordIdxWidth-1:0] wordIdx_t;

  // One bit per buffer word, bit i for word i
  typedef logic [wordsPerLine-1:0] wordMask_t;

endpackage : mbxGeometryPkg

//--- logic/mbxCyclePkg.sv
// Transfer and memory cycle kinds

package mbxCyclePkg;

  // Cache-to-buffer sequencer states
  typedef enum logic [2:0] {
    XferIdle = 3'd0,
    XferT1   = 3'd1,
    XferT2   = 3'd2,
    XferT3   = 3'd3,
    XferT4   = 3'd4
  } xferState_e;

  // Kind of the next memory cycle
  typedef enum logic [1:0] {
    CycIdle       = 2'd0,
    CycReadLine   = 2'd1,
    CycReadWord   = 2'd2,
    CycWriteWords = 2'd3
  } memCycle_e;

endpackage : mbxCyclePkg

//--- logic/mbWordIf.sv
// Per-word request set bus

interface mbWordIf;
  import mbxGeometryPkg::*;

  // Registered state of the set
  wordMask_t pendingMask;
  logic      anyPending;
  // Lowest pending word, 0 when nothing pending
  wordIdx_t  selIndex;

  // Requests into the set
  wordMask_t setMask;
  logic      clearSel;

  modport store (output pendingMask, anyPending, selIndex,
                 input  setMask, clearSel);

  modport control (output setMask, clearSel,
                   input  pendingMask, anyPending, selIndex);

  modport producer (output setMask,
                    input  anyPending, selIndex);

  modport consumer (output clearSel,
                    input  pendingMask, anyPending, selIndex);

endinterface : mbWordIf

//--- logic/wordRequestSet.sv
// Per-word pending request set

module wordRequestSet #(
  parameter int NumWords = mbxGeometryPkg::wordsPerLine
) (
  input logic   clk,
  input logic   rst,
  mbWordIf.store reqs
);

  localparam int IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic [NumWords-1:0] pending;
  logic [NumWords-1:0] clearMask;
  logic [IdxW-1:0]     selIdx;

  ////////////////////////////////////////
  // Lowest-index priority select
  ////////////////////////////////////////

  // Scan from the top so the lowest set bit is the one that sticks
  always_comb begin
    selIdx = '0;
    for (int i = NumWords - 1; i >= 0; i--) begin
      if (pending[i]) begin
        selIdx = IdxW'(i);
      end
    end
  end

  assign reqs.pendingMask = pending;
  assign reqs.anyPending  = |pending;
  assign reqs.selIndex    = selIdx;

  ////////////////////////////////////////
  // Pending register
  ////////////////////////////////////////

  // One-hot clear of the selected word
  always_comb begin
    clearMask = '0;
    if (reqs.clearSel) begin
      clearMask[selIdx] = 1'b1;
    end
  end

  // Set wins over a clear of the same word
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clearMask) | reqs.setMask;
    end
  end

endmodule : wordRequestSet

//--- logic/cacheTransferSeq.sv
// Cache to buffer transfer sequencer

module cacheTransferSeq (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      writebackStart,
  input  mbxGeometryPkg::wordMask_t validMask,
  input  logic                      phaseChangeComing,
  output logic                      memWrRq,
  output logic                      cacheToMbDone,
  mbWordIf.control                  xfer,
  mbWordIf.producer                 wrRq
);

  import mbxGeometryPkg::*;
  import mbxCyclePkg::*;

  xferState_e state;
  xferState_e stateNext;

  ////////////////////////////////////////
  // Next state and word moves
  ////////////////////////////////////////

  always_comb begin
    stateNext     = state;
    xfer.setMask  = '0;
    xfer.clearSel = 1'b0;
    wrRq.setMask  = '0;
    memWrRq       = 1'b0;
    cacheToMbDone = 1'b0;

    unique case (state)
      XferIdle: begin
        // Snapshot of the valid words starts a writeback
        if (writebackStart) begin
          xfer.setMask = validMask;
          stateNext    = XferT1;
        end
      end

      XferT1: begin
        if (!xfer.anyPending) begin
          cacheToMbDone = 1'b1;
          stateNext     = XferIdle;
        end else begin
          stateNext = XferT2;
        end
      end

      // Held here until the memory phase comes round
      XferT2: begin
        if (phaseChangeComing) begin
          stateNext = XferT3;
        end
      end

      XferT3: begin
        stateNext = XferT4;
      end

      XferT4: begin
        // Word lands in the buffer and now wants writing to memory
        memWrRq       = 1'b1;
        xfer.clearSel = 1'b1;
        wrRq.setMask  = wordMask_t'(1) << xfer.selIndex;
        stateNext     = XferT1;
      end

      default: begin
        stateNext = XferIdle;
      end
    endcase
  end

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= XferIdle;
    end else begin
      state <= stateNext;
    end
  end

endmodule : cacheTransferSeq

//--- logic/memRequestGen.sv
// Memory request cycle builder

module memRequestGen (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      readRequest,
  input  logic                      oneWordRead,
  input  mbxGeometryPkg::wordIdx_t  readAdr,
  input  mbxGeometryPkg::wordMask_t validMask,
  input  logic                      memAck,
  output mbxCyclePkg::memCycle_e    memCycle,
  output mbxGeometryPkg::wordMask_t memRqWords,
  mbWordIf.consumer                 wrRq
);

  import mbxGeometryPkg::*;
  import mbxCyclePkg::*;

  memCycle_e cycleNext;
  wordMask_t wordsNext;

  // Reads win over buffered writes
  always_comb begin
    if (readRequest && oneWordRead) begin
      cycleNext = CycReadWord;
      wordsNext = wordMask_t'(1) << readAdr;
    end else if (readRequest) begin
      // Line read fetches only the words the cache lacks
      wordsNext = ~validMask;
      cycleNext = (|wordsNext) ? CycReadLine : CycIdle;
    end else if (wrRq.anyPending) begin
      cycleNext = CycWriteWords;
      wordsNext = wrRq.pendingMask;
    end else begin
      cycleNext = CycIdle;
      wordsNext = '0;
    end
  end

  ////////////////////////////////////////
  // Registered request outputs
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      memCycle   <= CycIdle;
      memRqWords <= '0;
    end else begin
      memCycle   <= cycleNext;
      memRqWords <= wordsNext;
    end
  end

  // Acknowledge retires the word on the buffer select
  assign wrRq.clearSel = memAck;

endmodule : memRequestGen

//--- logic/mbxTop.sv
// Memory buffer control top level

module mbxTop (
  input  logic                      clk,
  input  logic                      rst,

  // Writeback side
  input  logic                      writebackStart,
  input  mbxGeometryPkg::wordMask_t validMask,
  input  logic                      phaseChangeComing,

  // Read requests from the cache
  input  logic                      readRequest,
  input  logic                      oneWordRead,
  input  mbxGeometryPkg::wordIdx_t  readAdr,

  // Memory side
  input  logic                      memAck,
  output mbxCyclePkg::memCycle_e    memCycle,
  output mbxGeometryPkg::wordMask_t memRqWords,
  output logic                      memWrRq,
  output logic                      cacheToMbDone,
  output mbxGeometryPkg::wordIdx_t  mbSel,
  output logic                      mbReqHold
);

  import mbxGeometryPkg::*;

  // Cache words still to move, and buffer words waiting for memory
  mbWordIf xferBus ();
  mbWordIf wrRqBus ();

  ////////////////////////////////////////
  // Request sets
  ////////////////////////////////////////

  wordRequestSet #(
    .NumWords (wordsPerLine)
  ) xferSet0 (
    .clk  (clk),
    .rst  (rst),
    .reqs (xferBus.store)
  );

  wordRequestSet #(
    .NumWords (wordsPerLine)
  ) wrRqSet0 (
    .clk  (clk),
    .rst  (rst),
    .reqs (wrRqBus.store)
  );

  ////////////////////////////////////////
  // Sequencer and request builder
  ////////////////////////////////////////

  cacheTransferSeq xferSeq0 (
    .clk               (clk),
    .rst               (rst),
    .writebackStart    (writebackStart),
    .validMask         (validMask),
    .phaseChangeComing (phaseChangeComing),
    .memWrRq           (memWrRq),
    .cacheToMbDone     (cacheToMbDone),
    .xfer              (xferBus.control),
    .wrRq              (wrRqBus.producer)
  );

  memRequestGen reqGen0 (
    .clk         (clk),
    .rst         (rst),
    .readRequest (readRequest),
    .oneWordRead (oneWordRead),
    .readAdr     (readAdr),
    .validMask   (validMask),
    .memAck      (memAck),
    .memCycle    (memCycle),
    .memRqWords  (memRqWords),
    .wrRq        (wrRqBus.consumer)
  );

  // Buffer select follows the lowest pending write
  assign mbSel     = wrRqBus.selIndex;
  assign mbReqHold = wrRqBus.anyPending;

endmodule : mbxTop

//--- tests/mbxTb.sv
// Memory buffer control testbench

module mbxTb;
  timeunit 1ns;
  timeprecision 1ps;

  import mbxGeometryPkg::*;
  import mbxCyclePkg::*;

  logic      clk;
  logic      rst;
  logic      writebackStart;
  wordMask_t validMask;
  logic      phaseChangeComing;
  logic      readRequest;
  logic      oneWordRead;
  wordIdx_t  readAdr;
  logic      memAck;
  memCycle_e memCycle;
  wordMask_t memRqWords;
  logic      memWrRq;
  logic      cacheToMbDone;
  wordIdx_t  mbSel;
  logic      mbReqHold;

  logic [15:0] lfsr = 16'd51733;
  int          checkCount = 0;
  int          errCount = 0;
  int          testCount = 0;
  int          testErrStart = 0;
  logic        holdPhase = 1'b0;
  wordMask_t   expPending = '0;

  mbxTop dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Assertions over the whole run
  ////////////////////////////////////////

  // A word move and the end of a transfer never share a cycle
  overlapCheck: assert property (@(posedge clk) disable iff (rst) !(memWrRq && cacheToMbDone))
    else begin
      errCount++;
      $display("memWrRq and cacheToMbDone were high in the same cycle");
    end

  holdCheck: assert property (@(posedge clk) disable iff (rst) !(holdPhase && memWrRq))
    else begin
      errCount++;
      $display("memWrRq rose while phaseChangeComing was held low");
    end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Taps 16 14 13 11 with one step per bit taken
  function automatic logic [7:0] takeBits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[6:0], fb};
    end
    return v;
  endfunction

  function automatic int lowestIdx(input wordMask_t m);
    for (int i = 0; i < wordsPerLine; i++) begin
      if (m[i]) begin
        return i;
      end
    end
    return 0;
  endfunction

  task automatic cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic checkVal(input string name, input int exp, input int act);
    checkCount++;
    assert (exp == act) else begin
      errCount++;
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errCount == testErrStart) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errCount - testErrStart);
    end
    testErrStart = errCount;
  endtask

  task automatic startWriteback(input wordMask_t m);
    cycle();
    writebackStart = 1'b1;
    validMask      = m;
    cycle();
    writebackStart = 1'b0;
  endtask

  // Counts word moves up to the end of the transfer
  task automatic waitTransfer(input string name, input wordMask_t m);
    int pulses;
    int dones;
    int n;
    pulses = 0;
    dones  = 0;
    n      = 0;
    while (dones == 0 && n < 200) begin
      @(negedge clk);
      if (memWrRq) pulses++;
      if (cacheToMbDone) dones++;
      n++;
    end
    if (dones == 0) begin
      errCount++;
      $display("Timeout in %s: cacheToMbDone never came", name);
    end
    // A second done would show up here
    repeat (4) begin
      @(negedge clk);
      if (cacheToMbDone) dones++;
    end
    checkVal({name, " memWrRq pulses"}, $countones(m), pulses);
    checkVal({name, " done pulses"}, 1, dones);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    wordMask_t m;
    wordMask_t expMask;
    wordIdx_t  a;
    int        gap;
    rst               = 1'b1;
    writebackStart    = 1'b0;
    validMask         = '0;
    phaseChangeComing = 1'b0;
    readRequest       = 1'b0;
    oneWordRead       = 1'b0;
    readAdr           = '0;
    memAck            = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    @(negedge clk);
    checkVal("reset memWrRq", 0, int'(memWrRq));
    checkVal("reset cacheToMbDone", 0, int'(cacheToMbDone));
    checkVal("reset mbReqHold", 0, int'(mbReqHold));
    checkVal("reset memCycle", int'(CycIdle), int'(memCycle));
    checkVal("reset memRqWords", 0, int'(memRqWords));
    finishTest("reset");

    m = wordMask_t'(takeBits(wordsPerLine));
    if (m == '0) m = wordMask_t'(5);
    cycle();
    phaseChangeComing = 1'b1;
    startWriteback(m);
    waitTransfer("writeback", m);
    expPending = m;
    checkVal("writeback memCycle", int'(CycWriteWords), int'(memCycle));
    checkVal("writeback memRqWords", int'(m), int'(memRqWords));
    finishTest("writeback");

    // Pending writes stay queued behind the reads
    for (int k = 0; k < 2; k++) begin
      m = (k == 0) ? wordMask_t'(takeBits(wordsPerLine)) : '1;
      expMask = ~m;
      cycle();
      readRequest = 1'b1;
      oneWordRead = 1'b0;
      validMask   = m;
      cycle();
      readRequest = 1'b0;
      @(negedge clk);
      checkVal("line read memCycle", int'((m == '1) ? CycIdle : CycReadLine), int'(memCycle));
      checkVal("line read memRqWords", int'(expMask), int'(memRqWords));
    end
    cycle();
    @(negedge clk);
    checkVal("line read then write memCycle", int'(CycWriteWords), int'(memCycle));
    checkVal("line read then write memRqWords", int'(expPending), int'(memRqWords));
    finishTest("line read");

    for (int k = 0; k < 4; k++) begin
      a = wordIdx_t'(takeBits(wordIdxWidth));
      expMask    = '0;
      expMask[a] = 1'b1;
      cycle();
      readRequest = 1'b1;
      oneWordRead = 1'b1;
      readAdr     = a;
      cycle();
      readRequest = 1'b0;
      oneWordRead = 1'b0;
      @(negedge clk);
      checkVal("word read memCycle", int'(CycReadWord), int'(memCycle));
      checkVal("word read memRqWords", int'(expMask), int'(memRqWords));
    end
    finishTest("word read");

    for (int k = 0; k < wordsPerLine && expPending != '0; k++) begin
      gap = int'(takeBits(2));
      for (int g = 0; g <= gap; g++) begin
        @(negedge clk);
        checkVal("ack mbSel", lowestIdx(expPending), int'(mbSel));
        checkVal("ack mbReqHold", 1, int'(mbReqHold));
        cycle();
      end
      memAck = 1'b1;
      cycle();
      memAck = 1'b0;
      expPending = expPending & (expPending - wordMask_t'(1));
    end
    @(negedge clk);
    checkVal("ack final mbReqHold", 0, int'(mbReqHold));
    finishTest("acknowledge");

    m = wordMask_t'(takeBits(wordsPerLine));
    if (m == '0) m = wordMask_t'(9);
    cycle();
    phaseChangeComing = 1'b0;
    startWriteback(m);
    holdPhase = 1'b1;
    repeat (20) cycle();
    holdPhase         = 1'b0;
    phaseChangeComing = 1'b1;
    waitTransfer("phase pacing", m);
    finishTest("phase pacing");

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : mbxTb

//--- sources.f
logic/mbxGeometryPkg.sv
logic/mbxCyclePkg.sv
logic/mbWordIf.sv
logic/wordRequestSet.sv
logic/cacheTransferSeq.sv
logic/memRequestGen.sv
logic/mbxTop.sv
tests/mbxTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mbxTb
RTL_TOP   ?= mbxTop
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter logic/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
